// File: hw/rv32i_types.sv
package rv32i_types;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;
  localparam int imem_addr_width = 32;

  // data memory, word index from address bits 7:2
  localparam int dmem_words = 64;
  localparam int dmem_index_width = $clog2(dmem_words);

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011
  } rv32i_opcode;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_ops;

  // funct3 of the alu groups
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_sr      = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 of lw and sw
  localparam logic [2:0] f3_word    = 3'b010;

  // funct7, alt picks sub and sra
  localparam logic [6:0] f7_base    = 7'b0000000;
  localparam logic [6:0] f7_alt     = 7'b0100000;

endpackage : rv32i_types

// File: hw/fetch_stage.sv
module fetch_stage
  import rv32i_types::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       stall,
  output logic [imem_addr_width-1:0] pc
);

  // sequential fetch only, no branches
  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= '0;
    else if (!stall)
      pc <= pc + imem_addr_width'(4);
  end

endmodule : fetch_stage

// File: hw/decode_stage.sv
module decode_stage
  import rv32i_types::*;
(
  input  logic [xlen-1:0]           instr,
  input  logic                      valid_in,
  input  logic [reg_addr_width-1:0] ex_rd,
  input  logic                      ex_is_load,
  input  logic                      ex_valid,
  output logic [reg_addr_width-1:0] rs1,
  output logic [reg_addr_width-1:0] rs2,
  output logic [reg_addr_width-1:0] rd,
  output rv32i_opcode               opcode,
  output alu_ops                    alu_op,
  output logic                      use_imm,
  output logic                      reg_write,
  output logic                      valid_out,
  output logic                      stall,
  output logic [xlen-1:0]           imm
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;
  logic       supported;
  logic       uses_rs2;
  alu_ops     arith_op;

  assign opcode = rv32i_opcode'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];
  assign alt    = (funct7 == f7_alt);

  // sub only exists in the register group
  always_comb
  begin
    case (funct3)
      f3_add_sub: arith_op = (alt && opcode == op_reg) ? alu_sub : alu_add;
      f3_sll:     arith_op = alu_sll;
      f3_slt:     arith_op = alu_slt;
      f3_sltu:    arith_op = alu_sltu;
      f3_xor:     arith_op = alu_xor;
      f3_sr:      arith_op = alt ? alu_sra : alu_srl;
      f3_or:      arith_op = alu_or;
      f3_and:     arith_op = alu_and;
    endcase
  end

  always_comb
  begin
    case (opcode)
      op_lui:
        supported = 1'b1;
      op_imm:
        if (funct3 == f3_sll)
          supported = (funct7 == f7_base);
        else if (funct3 == f3_sr)
          supported = (funct7 == f7_base) || alt;
        else
          supported = 1'b1;
      op_reg:
        if (funct3 == f3_add_sub || funct3 == f3_sr)
          supported = (funct7 == f7_base) || alt;
        else
          supported = (funct7 == f7_base);
      op_load, op_store:
        supported = (funct3 == f3_word);
      default:
        supported = 1'b0;
    endcase
  end

  // one immediate, picked by format
  always_comb
  begin
    case (opcode)
      op_lui:   imm = {instr[31:12], 12'b0};
      op_store: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      default:  imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  assign alu_op    = (opcode == op_imm || opcode == op_reg) ? arith_op : alu_add;
  assign use_imm   = (opcode != op_reg);
  assign reg_write = (opcode == op_lui) || (opcode == op_imm) ||
                     (opcode == op_reg) || (opcode == op_load);
  assign valid_out = valid_in && supported;

  // load in execute feeding this instruction
  assign uses_rs2 = (opcode == op_reg) || (opcode == op_store);
  assign stall    = valid_in && ex_valid && ex_is_load && (ex_rd != '0) &&
                    ((ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

endmodule : decode_stage

// File: hw/reg_file.sv
module reg_file
  import rv32i_types::*;
(
  input  logic                      clk,
  input  logic [reg_addr_width-1:0] rs1,
  input  logic [reg_addr_width-1:0] rs2,
  input  logic                      we,
  input  logic [reg_addr_width-1:0] wa,
  input  logic [xlen-1:0]           wd,
  output logic [xlen-1:0]           rd1,
  output logic [xlen-1:0]           rd2
);

  // no storage for x0
  logic [xlen-1:0] regs [1:(1 << reg_addr_width) - 1];

  always_ff @(posedge clk)
  begin
    if (we && wa != '0)
      regs[wa] <= wd;
  end

  // writeback data bypasses the array in the same cycle
  assign rd1 = (rs1 == '0) ? '0 : (we && wa == rs1) ? wd : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : (we && wa == rs2) ? wd : regs[rs2];

endmodule : reg_file

// File: hw/pipe_regs.sv
module if_id_reg
  import rv32i_types::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       valid_in,
  input  logic [imem_addr_width-1:0] pc_in,
  input  logic [xlen-1:0]            instr_in,
  output logic                       valid_out,
  output logic [imem_addr_width-1:0] pc_out,
  output logic [xlen-1:0]            instr_out
);

  always_ff @(posedge clk)
  begin
    if (reset)
      valid_out <= 1'b0;
    else if (load)
      valid_out <= valid_in;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      pc_out    <= pc_in;
      instr_out <= instr_in;
    end
  end

endmodule : if_id_reg


module id_ex_reg
  import rv32i_types::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      bubble,
  input  logic                      valid_in,
  input  rv32i_opcode               opcode_in,
  input  alu_ops                    alu_op_in,
  input  logic                      use_imm_in,
  input  logic                      reg_write_in,
  input  logic [reg_addr_width-1:0] rd_in,
  input  logic [reg_addr_width-1:0] rs1_in,
  input  logic [reg_addr_width-1:0] rs2_in,
  input  logic [xlen-1:0]           imm_in,
  input  logic [xlen-1:0]           rs1out_in,
  input  logic [xlen-1:0]           rs2out_in,
  output logic                      valid_out,
  output rv32i_opcode               opcode_out,
  output alu_ops                    alu_op_out,
  output logic                      use_imm_out,
  output logic                      reg_write_out,
  output logic [reg_addr_width-1:0] rd_out,
  output logic [reg_addr_width-1:0] rs1_out,
  output logic [reg_addr_width-1:0] rs2_out,
  output logic [xlen-1:0]           imm_out,
  output logic [xlen-1:0]           rs1out_out,
  output logic [xlen-1:0]           rs2out_out
);

  // a bubble goes in while decode stalls
  always_ff @(posedge clk)
  begin
    if (reset)
      valid_out <= 1'b0;
    else if (load)
      valid_out <= valid_in && !bubble;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      opcode_out    <= opcode_in;
      alu_op_out    <= alu_op_in;
      use_imm_out   <= use_imm_in;
      reg_write_out <= reg_write_in;
      rd_out        <= rd_in;
      rs1_out       <= rs1_in;
      rs2_out       <= rs2_in;
      imm_out       <= imm_in;
      rs1out_out    <= rs1out_in;
      rs2out_out    <= rs2out_in;
    end
  end

endmodule : id_ex_reg


module ex_mem_reg
  import rv32i_types::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      valid_in,
  input  rv32i_opcode               opcode_in,
  input  logic                      reg_write_in,
  input  logic [reg_addr_width-1:0] rd_in,
  input  logic [xlen-1:0]           aluout_in,
  input  logic [xlen-1:0]           rs2out_in,
  output logic                      valid_out,
  output rv32i_opcode               opcode_out,
  output logic                      reg_write_out,
  output logic [reg_addr_width-1:0] rd_out,
  output logic [xlen-1:0]           aluout_out,
  output logic [xlen-1:0]           rs2out_out
);

  always_ff @(posedge clk)
  begin
    if (reset)
      valid_out <= 1'b0;
    else if (load)
      valid_out <= valid_in;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      opcode_out    <= opcode_in;
      reg_write_out <= reg_write_in;
      rd_out        <= rd_in;
      aluout_out    <= aluout_in;
      rs2out_out    <= rs2out_in;
    end
  end

endmodule : ex_mem_reg


module mem_wb_reg
  import rv32i_types::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      valid_in,
  input  rv32i_opcode               opcode_in,
  input  logic                      reg_write_in,
  input  logic [reg_addr_width-1:0] rd_in,
  input  logic [xlen-1:0]           aluout_in,
  input  logic [xlen-1:0]           dmemout_in,
  output logic                      valid_out,
  output rv32i_opcode               opcode_out,
  output logic                      reg_write_out,
  output logic [reg_addr_width-1:0] rd_out,
  output logic [xlen-1:0]           aluout_out,
  output logic [xlen-1:0]           dmemout_out
);

  always_ff @(posedge clk)
  begin
    if (reset)
      valid_out <= 1'b0;
    else if (load)
      valid_out <= valid_in;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      opcode_out    <= opcode_in;
      reg_write_out <= reg_write_in;
      rd_out        <= rd_in;
      aluout_out    <= aluout_in;
      dmemout_out   <= dmemout_in;
    end
  end

endmodule : mem_wb_reg

// File: hw/execute_stage.sv
module execute_stage
  import rv32i_types::*;
(
  input  alu_ops                    alu_op,
  input  logic                      use_imm,
  input  logic [xlen-1:0]           imm,
  input  logic [reg_addr_width-1:0] rs1,
  input  logic [reg_addr_width-1:0] rs2,
  input  logic [xlen-1:0]           rs1out,
  input  logic [xlen-1:0]           rs2out,
  input  rv32i_opcode               opcode,
  input  logic [reg_addr_width-1:0] exm_rd,
  input  logic                      exm_reg_write,
  input  logic                      exm_valid,
  input  logic                      exm_is_load,
  input  logic [xlen-1:0]           exm_aluout,
  input  logic [reg_addr_width-1:0] wb_rd,
  input  logic                      wb_write,
  input  logic [xlen-1:0]           wb_data,
  output logic [xlen-1:0]           aluout,
  output logic [xlen-1:0]           store_data
);

  logic [xlen-1:0] src_a;
  logic [xlen-1:0] src_b;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic [xlen-1:0] alu_result;

  // newest producer wins, a load in ex_mem has no data yet
  function automatic logic [xlen-1:0] forward(
    input logic [reg_addr_width-1:0] rs,
    input logic [xlen-1:0]           rf_value
  );
    logic [xlen-1:0] value;
    if (rs == '0)
      value = rf_value;
    else if (exm_valid && exm_reg_write && !exm_is_load && exm_rd == rs)
      value = exm_aluout;
    else if (wb_write && wb_rd == rs)
      value = wb_data;
    else
      value = rf_value;
    return value;
  endfunction

  always_comb
  begin
    src_a = forward(rs1, rs1out);
    src_b = forward(rs2, rs2out);
  end

  assign op_b  = use_imm ? imm : src_b;
  assign shamt = op_b[4:0];

  always_comb
  begin
    case (alu_op)
      alu_add:  alu_result = src_a + op_b;
      alu_sub:  alu_result = src_a - op_b;
      alu_sll:  alu_result = src_a << shamt;
      alu_slt:  alu_result = {{(xlen - 1){1'b0}}, $signed(src_a) < $signed(op_b)};
      alu_sltu: alu_result = {{(xlen - 1){1'b0}}, src_a < op_b};
      alu_xor:  alu_result = src_a ^ op_b;
      alu_srl:  alu_result = src_a >> shamt;
      alu_sra:  alu_result = $signed(src_a) >>> shamt;
      alu_or:   alu_result = src_a | op_b;
      alu_and:  alu_result = src_a & op_b;
      default:  alu_result = src_a + op_b;
    endcase
  end

  // lui bypasses the alu
  assign aluout     = (opcode == op_lui) ? imm : alu_result;
  assign store_data = src_b;

endmodule : execute_stage

// File: hw/data_mem.sv
module data_mem
  import rv32i_types::*;
(
  input  logic            clk,
  input  logic            we,
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] wdata,
  output logic [xlen-1:0] rdata
);

  logic [xlen-1:0]             mem [dmem_words];
  logic [dmem_index_width-1:0] index;

  // upper address bits wrap
  assign index = addr[dmem_index_width + 1:2];

  always_ff @(posedge clk)
  begin
    if (we)
      mem[index] <= wdata;
  end

  assign rdata = mem[index];

endmodule : data_mem

// File: hw/rv32i_pipeline.sv
module rv32i_pipeline
  import rv32i_types::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [xlen-1:0]            imem_rdata,
  output logic [imem_addr_width-1:0] imem_addr,
  output logic                       wb_valid,
  output logic [reg_addr_width-1:0]  wb_rd,
  output logic [xlen-1:0]            wb_data
);

  logic                      stall;
  logic                      if_valid;
  logic [xlen-1:0]           if_instr;

  logic                      id_valid, id_use_imm, id_reg_write;
  logic [reg_addr_width-1:0] id_rs1, id_rs2, id_rd;
  logic [xlen-1:0]           id_imm, id_rs1out, id_rs2out;
  rv32i_opcode               id_opcode;
  alu_ops                    id_alu_op;

  logic                      ex_valid, ex_use_imm, ex_reg_write, ex_is_load;
  logic [reg_addr_width-1:0] ex_rs1, ex_rs2, ex_rd;
  logic [xlen-1:0]           ex_imm, ex_rs1out, ex_rs2out, ex_aluout, ex_store_data;
  rv32i_opcode               ex_opcode;
  alu_ops                    ex_alu_op;

  logic                      mem_valid, mem_reg_write, mem_is_load, dmem_we;
  logic [reg_addr_width-1:0] mem_rd;
  logic [xlen-1:0]           mem_aluout, mem_rs2out, mem_dmemout;
  rv32i_opcode               mem_opcode;

  logic                      wb_stage_valid, wb_reg_write;
  logic [xlen-1:0]           wb_aluout, wb_dmemout;
  rv32i_opcode               wb_opcode;

  assign ex_is_load  = (ex_opcode == op_load);
  assign mem_is_load = (mem_opcode == op_load);
  assign dmem_we     = mem_valid && (mem_opcode == op_store);

  fetch_stage u_fetch_stage (.clk(clk), .reset(reset), .stall(stall), .pc(imem_addr));

  // fetch and decode hold while a load-use stall is pending
  if_id_reg u_if_id_reg (
    .clk(clk), .reset(reset), .load(!stall), .valid_in(1'b1),
    .pc_in(imem_addr), .instr_in(imem_rdata),
    .valid_out(if_valid), .pc_out(), .instr_out(if_instr)
  );

  decode_stage u_decode_stage (
    .instr(if_instr), .valid_in(if_valid),
    .ex_rd(ex_rd), .ex_is_load(ex_is_load), .ex_valid(ex_valid),
    .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .opcode(id_opcode), .alu_op(id_alu_op),
    .use_imm(id_use_imm), .reg_write(id_reg_write), .valid_out(id_valid),
    .stall(stall), .imm(id_imm)
  );

  reg_file u_reg_file (
    .clk(clk), .rs1(id_rs1), .rs2(id_rs2),
    .we(wb_valid), .wa(wb_rd), .wd(wb_data),
    .rd1(id_rs1out), .rd2(id_rs2out)
  );

  id_ex_reg u_id_ex_reg (
    .clk(clk), .reset(reset), .load(1'b1), .bubble(stall), .valid_in(id_valid),
    .opcode_in(id_opcode), .alu_op_in(id_alu_op), .use_imm_in(id_use_imm),
    .reg_write_in(id_reg_write), .rd_in(id_rd), .rs1_in(id_rs1), .rs2_in(id_rs2),
    .imm_in(id_imm), .rs1out_in(id_rs1out), .rs2out_in(id_rs2out),
    .valid_out(ex_valid), .opcode_out(ex_opcode), .alu_op_out(ex_alu_op),
    .use_imm_out(ex_use_imm), .reg_write_out(ex_reg_write), .rd_out(ex_rd),
    .rs1_out(ex_rs1), .rs2_out(ex_rs2), .imm_out(ex_imm),
    .rs1out_out(ex_rs1out), .rs2out_out(ex_rs2out)
  );

  execute_stage u_execute_stage (
    .alu_op(ex_alu_op), .use_imm(ex_use_imm), .imm(ex_imm),
    .rs1(ex_rs1), .rs2(ex_rs2), .rs1out(ex_rs1out), .rs2out(ex_rs2out),
    .opcode(ex_opcode),
    .exm_rd(mem_rd), .exm_reg_write(mem_reg_write), .exm_valid(mem_valid),
    .exm_is_load(mem_is_load), .exm_aluout(mem_aluout),
    .wb_rd(wb_rd), .wb_write(wb_valid), .wb_data(wb_data),
    .aluout(ex_aluout), .store_data(ex_store_data)
  );

  ex_mem_reg u_ex_mem_reg (
    .clk(clk), .reset(reset), .load(1'b1), .valid_in(ex_valid),
    .opcode_in(ex_opcode), .reg_write_in(ex_reg_write), .rd_in(ex_rd),
    .aluout_in(ex_aluout), .rs2out_in(ex_store_data),
    .valid_out(mem_valid), .opcode_out(mem_opcode), .reg_write_out(mem_reg_write),
    .rd_out(mem_rd), .aluout_out(mem_aluout), .rs2out_out(mem_rs2out)
  );

  data_mem u_data_mem (
    .clk(clk), .we(dmem_we), .addr(mem_aluout), .wdata(mem_rs2out), .rdata(mem_dmemout)
  );

  mem_wb_reg u_mem_wb_reg (
    .clk(clk), .reset(reset), .load(1'b1), .valid_in(mem_valid),
    .opcode_in(mem_opcode), .reg_write_in(mem_reg_write), .rd_in(mem_rd),
    .aluout_in(mem_aluout), .dmemout_in(mem_dmemout),
    .valid_out(wb_stage_valid), .opcode_out(wb_opcode), .reg_write_out(wb_reg_write),
    .rd_out(wb_rd), .aluout_out(wb_aluout), .dmemout_out(wb_dmemout)
  );

  // x0 writes never leave the core
  assign wb_valid = wb_stage_valid && wb_reg_write && (wb_rd != '0);
  assign wb_data  = (wb_opcode == op_load) ? wb_dmemout : wb_aluout;

endmodule : rv32i_pipeline

// File: testbench/rv32i_asserts.sv
module rv32i_asserts
  import rv32i_types::*;
(
  input logic                       clk,
  input logic                       reset,
  input logic                       stall,
  input logic [imem_addr_width-1:0] imem_addr,
  input logic                       wb_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // valid bits clear on the first reset edge
  wb_quiet_in_reset: assert property (@(posedge clk) reset |=> !wb_valid)
    else $error("wb_valid high while reset is held");

  // the bubble behind a stall cannot be a load
  single_cycle_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> !stall)
    else $error("load-use stall lasted two cycles");

  pc_holds_on_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(imem_addr))
    else $error("imem_addr moved during a stall");

endmodule : rv32i_asserts

bind rv32i_pipeline rv32i_asserts u_rv32i_asserts (
  .clk(clk), .reset(reset), .stall(stall), .imem_addr(imem_addr), .wb_valid(wb_valid)
);

// File: testbench/tb_rv32i.sv
module tb_rv32i
  import rv32i_types::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int prog_len = 231;
  localparam int imem_words = 256;
  localparam int timeout_cycles = 2000;
  localparam int quiet_cycles = 20;
  localparam logic [31:0] nop_word = 32'h00000013;

  // instruction kinds of the program generator
  localparam int k_lui = 0, k_addi = 1, k_slti = 2, k_sltiu = 3, k_xori = 4, k_ori = 5,
                 k_andi = 6, k_slli = 7, k_srli = 8, k_srai = 9, k_add = 10, k_sub = 11,
                 k_sll = 12, k_slt = 13, k_sltu = 14, k_xor = 15, k_or = 16, k_and = 17,
                 k_srl = 18, k_sra = 19, k_lw = 20, k_sw = 21;

  logic        clk = 1'b0;
  logic        reset;
  logic [31:0] imem_rdata;
  logic [31:0] imem_addr;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  int          seed;
  logic [31:0] imem [imem_words];
  int          prog_kind [prog_len];
  logic [4:0]  prog_rd [prog_len];
  logic [4:0]  prog_rs1 [prog_len];
  logic [4:0]  prog_rs2 [prog_len];
  logic [31:0] prog_imm [prog_len];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [31:0] last_pc;
  bit          pc_seen;

  rv32i_pipeline u_rv32i_pipeline (
    .clk(clk), .reset(reset), .imem_rdata(imem_rdata), .imem_addr(imem_addr),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] encode(input int kind, input logic [4:0] rd, rs1, rs2,
                                         input logic [31:0] imm);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (kind == k_sub || kind == k_sra || kind == k_srai) ? 7'b0100000 : 7'b0000000;
    case (kind)
      k_slli, k_sll: f3 = 3'b001;
      k_slti, k_slt, k_lw, k_sw: f3 = 3'b010;
      k_sltiu, k_sltu: f3 = 3'b011;
      k_xori, k_xor: f3 = 3'b100;
      k_srli, k_srai, k_srl, k_sra: f3 = 3'b101;
      k_ori, k_or: f3 = 3'b110;
      k_andi, k_and: f3 = 3'b111;
      default: f3 = 3'b000;
    endcase
    if (kind == k_lui)
      return {imm[31:12], rd, op_lui};
    else if (kind >= k_slli && kind <= k_srai)
      return {f7, imm[4:0], rs1, f3, rd, op_imm};
    else if (kind < k_add)
      return {imm[11:0], rs1, f3, rd, op_imm};
    else if (kind < k_lw)
      return {f7, rs2, rs1, f3, rd, op_reg};
    else if (kind == k_lw)
      return {imm[11:0], rs1, f3, rd, op_load};
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  // isa result of one alu kind with b as the immediate of the I forms
  function automatic logic [31:0] alu_ref(input int kind, input logic [31:0] a, b);
    case (kind)
      k_addi, k_add: return a + b;
      k_sub: return a - b;
      k_slti, k_slt: return {31'b0, $signed(a) < $signed(b)};
      k_sltiu, k_sltu: return {31'b0, a < b};
      k_xori, k_xor: return a ^ b;
      k_ori, k_or: return a | b;
      k_andi, k_and: return a & b;
      k_slli, k_sll: return a << b[4:0];
      k_srli, k_srl: return a >> b[4:0];
      k_srai, k_sra: return $signed(a) >>> b[4:0];
      default: return b;
    endcase
  endfunction

  task automatic set_instr(input int idx, kind, input logic [4:0] rd, rs1, rs2,
                           input logic [31:0] imm);
    prog_kind[idx] = kind;
    prog_rd[idx] = rd;
    prog_rs1[idx] = rs1;
    prog_rs2[idx] = rs2;
    prog_imm[idx] = imm;
    imem[idx] = encode(kind, rd, rs1, rs2, imm);
  endtask

  task automatic build_program();
    int          kind;
    logic [31:0] r;
    logic [31:0] imm;
    logic [5:0]  word_idx;
    bit          stored [64];
    for (int i = 0; i < imem_words; i++)
      imem[i] = nop_word;
    // each of x1..x31 in turn from the one before
    for (int i = 1; i < 32; i++)
    begin
      r = $random(seed);
      set_instr(i - 1, k_addi, 5'(i), 5'(i - 1), 5'd0, {{20{r[11]}}, r[11:0]});
    end
    for (int i = 31; i < prog_len; i++)
    begin
      kind = $unsigned($random(seed)) % 30;
      if (kind > k_sw)
        kind = (kind % 2) ? k_lw : k_sw;
      r = $random(seed);
      imm = $random(seed);
      word_idx = imm[5:0];
      // never load a word that was not stored
      if (kind == k_lw && !stored[word_idx])
        kind = k_sw;
      if (kind >= k_lw)
      begin
        stored[word_idx] = 1'b1;
        imm = {24'b0, word_idx, 2'b00};
      end
      else if (kind == k_lui)
        imm = {imm[31:12], 12'b0};
      else if (kind >= k_slli && kind <= k_srai)
        imm = {27'b0, imm[4:0]};
      else
        imm = {{20{imm[11]}}, imm[11:0]};
      set_instr(i, kind, {2'b0, r[2:0]}, (kind >= k_lw) ? 5'd0 : {2'b0, r[5:3]},
                {2'b0, r[8:6]}, imm);
    end
  endtask

  function automatic void ref_model();
    logic [31:0] regs [32];
    logic [31:0] mem [64];
    logic [31:0] a, b, addr, value;
    for (int r = 0; r < 32; r++)
      regs[r] = '0;
    for (int i = 0; i < prog_len; i++)
    begin
      a = regs[prog_rs1[i]];
      b = regs[prog_rs2[i]];
      addr = a + prog_imm[i];
      if (prog_kind[i] == k_sw)
        mem[addr[7:2]] = b;
      else
      begin
        if (prog_kind[i] == k_lw)
          value = mem[addr[7:2]];
        else if (prog_kind[i] >= k_add)
          value = alu_ref(prog_kind[i], a, b);
        else
          value = alu_ref(prog_kind[i], a, prog_imm[i]);
        if (prog_rd[i] != 5'd0)
        begin
          regs[prog_rd[i]] = value;
          exp_rd.push_back(prog_rd[i]);
          exp_data.push_back(value);
        end
      end
    end
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr < 4 * imem_words)
      return imem[addr[9:2]];
    return nop_word;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  always @(posedge clk)
  begin
    #1;
    imem_rdata = fetch_word(imem_addr);
  end

  // pc starts at zero and either holds or steps one word
  always @(posedge clk)
  begin
    if (reset)
      pc_seen = 1'b0;
    else if (!pc_seen)
    begin
      assert (imem_addr === 32'd0)
      else stop_on_error($sformatf("Mismatch at %0t: imem_addr is %h, expected %h",
                                   $time, imem_addr, 32'd0));
      last_pc = imem_addr;
      pc_seen = 1'b1;
    end
    else
    begin
      assert (imem_addr === last_pc || imem_addr === last_pc + 32'd4)
      else stop_on_error($sformatf("Mismatch at %0t: imem_addr is %h, expected %h or %h",
                                   $time, imem_addr, last_pc, last_pc + 32'd4));
      last_pc = imem_addr;
    end
  end

  always @(posedge clk)
  begin
    if (!reset && wb_valid === 1'b1)
    begin
      assert (exp_rd.size() != 0)
      else stop_on_error($sformatf("extra register write to x%0d at %0t", wb_rd, $time));
      assert (wb_rd === exp_rd[0])
      else stop_on_error($sformatf("Mismatch at %0t: wb_rd is %0d, expected %0d",
                                   $time, wb_rd, exp_rd[0]));
      assert (wb_data === exp_data[0])
      else stop_on_error($sformatf("Mismatch at %0t: wb_data is %h, expected %h",
                                   $time, wb_data, exp_data[0]));
      void'(exp_rd.pop_front());
      void'(exp_data.pop_front());
    end
  end

  initial
  begin
    int wait_cycles;
    seed = 13;
    reset = 1'b1;
    imem_rdata = nop_word;
    build_program();
    ref_model();
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_cycles = 0;
    while (exp_rd.size() != 0 && wait_cycles < timeout_cycles)
    begin
      @(negedge clk);
      wait_cycles++;
    end
    if (exp_rd.size() == 0)
    begin
      // padding writes only x0 so the port must stay quiet
      repeat (quiet_cycles) @(posedge clk);
      @(negedge clk);
      $display("Regression passed");
      $finish;
    end
    else
      stop_on_error($sformatf("expected writes did not all arrive, %0d left after %0d cycles",
                              exp_rd.size(), timeout_cycles));
  end

endmodule : tb_rv32i

// File: tb.f
hw/rv32i_types.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/pipe_regs.sv
hw/execute_stage.sv
hw/data_mem.sv
hw/rv32i_pipeline.sv
testbench/rv32i_asserts.sv
testbench/tb_rv32i.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv32i -f tb.f \
  -o sim_rv32i \
  && ./obj_dir/sim_rv32i | tee /dev/stderr | grep -q "^Regression passed$" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
